// File: ringCtrl.f
design/ringPkg.sv
design/localQueue.sv
design/reqIngress.sv
design/rspIngress.sv
design/ringEgress.sv
design/ringCtrl.sv
tb/ringCtrl_properties.sv
tb/ringCtrlTb.sv

// File: tb/ringCtrlTb.sv
// Testbench for the ring controller
// Random ring and core traffic from a fixed seed
// Reference model with delayed ring decisions, scoreboards and a watchdog
`default_nettype none

module ringCtrlTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         ClkPeriod    = 100;
    localparam int         NumCycles    = 3000;
    localparam int         VentLimit    = 3;
    localparam int         QueueDepth   = 4;
    localparam int         WatchdogTime = (NumCycles + 100) * ClkPeriod;
    localparam logic [7:0] CoreId       = 8'd5;

    logic              QClk   = 1'b0;
    logic              reset  = 1'b1;
    logic [7:0]        coreId = CoreId;
    logic              reqInValid;
    ringPkg::ringMsg_t reqInMsg;
    logic              rspInValid;
    ringPkg::ringMsg_t rspInMsg;
    logic              reqOutValid;
    ringPkg::ringMsg_t reqOutMsg;
    logic              rspOutValid;
    ringPkg::ringMsg_t rspOutMsg;
    logic              coreReqValid;
    ringPkg::opcode_t  coreReqOpcode;
    logic [31:0]       coreReqAddress;
    logic [31:0]       coreReqData;
    logic [1:0]        coreReqThread;
    logic              coreReqStall;
    logic              coreRspValid;
    ringPkg::ringMsg_t coreRspMsg;
    logic              coreRspStall;
    logic              coreInReqValid;
    ringPkg::opcode_t  coreInReqOpcode;
    logic [31:0]       coreInReqAddress;
    logic [31:0]       coreInReqData;
    logic              coreInRspValid;
    ringPkg::opcode_t  coreInRspOpcode;
    logic [31:0]       coreInRspData;
    logic [1:0]        coreInRspThread;

    int                seed = 79;
    logic              reqFwdPipe [2] = '{1'b0, 1'b0};  // Index 1 is two cycles old
    logic              reqDlvPipe [2] = '{1'b0, 1'b0};
    ringPkg::ringMsg_t reqMsgPipe [2];
    logic              rspFwdPipe [2] = '{1'b0, 1'b0};
    logic              rspDlvPipe [2] = '{1'b0, 1'b0};
    ringPkg::ringMsg_t rspMsgPipe [2];
    ringPkg::ringMsg_t reqSb [$];  // Pushed core requests in order
    ringPkg::ringMsg_t rspSb [$];
    int                reqRun = 0; // Local insertions since last bubble or forward
    int                rspRun = 0;
    logic              reqStallSeen = 1'b0;
    logic              rspStallSeen = 1'b0;

    ringCtrl u_dut (.*);

    initial begin
        forever #(ClkPeriod / 2) QClk = ~QClk;
    end

    //========================================
    // Helpers
    //========================================
    function automatic logic [7:0] pickCore();
        return 8'(5 + {$random(seed)} % 3);  // One of cores 5, 6, 7
    endfunction

    function automatic ringPkg::ringMsg_t randomMsg();
        ringPkg::ringMsg_t msg;
        msg.requestor = {pickCore(), 2'($random(seed))};
        msg.opcode    = ringPkg::opcode_t'(2'($random(seed)));
        msg.address   = {pickCore(), 24'($random(seed))};  // Target core on top
        msg.data      = $random(seed);
        return msg;
    endfunction

    task automatic compareValues(input logic [127:0] actual, input logic [127:0] expected,
            input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // One ring output slot: due forward, next local entry, or bubble
    task automatic checkSlot(input logic outValid, input ringPkg::ringMsg_t outMsg,
            input logic fwdDue, input ringPkg::ringMsg_t fwdMsg, input logic haveEntry,
            input ringPkg::ringMsg_t entry, inout int run, output logic tookEntry,
            input string chan);
        tookEntry = 1'b0;
        if (fwdDue) begin
            compareValues(outValid, 1'b1, {chan, " forward valid"});
            compareValues(outMsg, fwdMsg, {chan, " forwarded message"});
            run = 0;
        end else if (outValid) begin
            compareValues(haveEntry, 1'b1, {chan, " insertion with empty scoreboard"});
            compareValues(outMsg, entry, {chan, " inserted message"});
            run++;
            compareValues(run <= VentLimit, 1'b1, {chan, " insertions without ventilation"});
            tookEntry = 1'b1;
        end else begin
            run = 0;  // Bubble
        end
    endtask

    //========================================
    // Model and checks, sampled mid cycle
    //========================================
    initial begin : model
        logic took;
        logic isBcast;
        logic ownSrc;
        logic forMe;
        wait (!reset);
        forever begin
            @(negedge QClk);
            checkSlot(reqOutValid, reqOutMsg, reqFwdPipe[1], reqMsgPipe[1], reqSb.size() > 0,
                (reqSb.size() > 0) ? reqSb[0] : '0, reqRun, took, "request ring");
            if (took) void'(reqSb.pop_front());
            // Entries still waiting equal the queue occupancy
            compareValues(coreReqStall, reqSb.size() == QueueDepth, "request stall level");
            checkSlot(rspOutValid, rspOutMsg, rspFwdPipe[1], rspMsgPipe[1], rspSb.size() > 0,
                (rspSb.size() > 0) ? rspSb[0] : '0, rspRun, took, "response ring");
            if (took) void'(rspSb.pop_front());
            compareValues(coreRspStall, rspSb.size() == QueueDepth, "response stall level");
            compareValues(coreInReqValid, reqDlvPipe[1], "request delivery valid");
            if (reqDlvPipe[1]) begin
                compareValues(coreInReqOpcode, reqMsgPipe[1].opcode, "request delivery opcode");
                compareValues(coreInReqAddress, reqMsgPipe[1].address, "request delivery address");
                compareValues(coreInReqData, reqMsgPipe[1].data, "request delivery data");
            end
            compareValues(coreInRspValid, rspDlvPipe[1], "response delivery valid");
            if (rspDlvPipe[1]) begin
                compareValues(coreInRspOpcode, rspMsgPipe[1].opcode, "response delivery opcode");
                compareValues(coreInRspData, rspMsgPipe[1].data, "response delivery data");
                compareValues(coreInRspThread, rspMsgPipe[1].requestor[1:0], "response thread");
            end
            reqFwdPipe[1] = reqFwdPipe[0];
            reqDlvPipe[1] = reqDlvPipe[0];
            reqMsgPipe[1] = reqMsgPipe[0];
            rspFwdPipe[1] = rspFwdPipe[0];
            rspDlvPipe[1] = rspDlvPipe[0];
            rspMsgPipe[1] = rspMsgPipe[0];
            // Request rule, broadcast goes both ways unless it is our own
            isBcast       = (reqInMsg.opcode == ringPkg::WrBcast);
            ownSrc        = (reqInMsg.requestor[9:2] == CoreId);
            forMe         = (reqInMsg.address[31:24] == CoreId);
            reqMsgPipe[0] = reqInMsg;
            reqFwdPipe[0] = reqInValid && (isBcast ? !ownSrc : !forMe);
            reqDlvPipe[0] = reqInValid && (isBcast ? !ownSrc : forMe);
            rspMsgPipe[0] = rspInMsg;
            rspFwdPipe[0] = rspInValid && (rspInMsg.requestor[9:2] != CoreId);
            rspDlvPipe[0] = rspInValid && (rspInMsg.requestor[9:2] == CoreId);
            if (coreReqValid) begin
                reqSb.push_back({CoreId, coreReqThread, coreReqOpcode, coreReqAddress,
                    coreReqData});
            end
            if (coreRspValid) rspSb.push_back(coreRspMsg);
            reqStallSeen = coreReqStall;
            rspStallSeen = coreRspStall;
        end
    end

    //========================================
    // Stimulus
    //========================================
    initial begin : stimulus
        logic reqPushedLast;
        logic rspPushedLast;
        int   drainWait;
        reqInValid     = 1'b0;
        reqInMsg       = '0;
        rspInValid     = 1'b0;
        rspInMsg       = '0;
        coreReqValid   = 1'b0;
        coreReqOpcode  = ringPkg::Rd;
        coreReqAddress = '0;
        coreReqData    = '0;
        coreReqThread  = '0;
        coreRspValid   = 1'b0;
        coreRspMsg     = '0;
        reqPushedLast  = 1'b0;
        rspPushedLast  = 1'b0;
        repeat (8) @(posedge QClk);
        reset <= 1'b0;
        repeat (NumCycles) begin
            @(posedge QClk);
            reqInValid <= ({$random(seed)} % 100) < 60;
            reqInMsg   <= randomMsg();
            rspInValid <= ({$random(seed)} % 100) < 60;
            rspInMsg   <= randomMsg();
            // Skip a cycle after each push so the sampled stall is still current
            if (!reqPushedLast && !reqStallSeen && ({$random(seed)} % 100) < 70) begin
                coreReqValid   <= 1'b1;
                coreReqOpcode  <= ringPkg::opcode_t'(2'($random(seed)));
                coreReqAddress <= {pickCore(), 24'($random(seed))};
                coreReqData    <= $random(seed);
                coreReqThread  <= 2'($random(seed));
                reqPushedLast = 1'b1;
            end else begin
                coreReqValid <= 1'b0;
                reqPushedLast = 1'b0;
            end
            if (!rspPushedLast && !rspStallSeen && ({$random(seed)} % 100) < 70) begin
                coreRspValid <= 1'b1;
                coreRspMsg   <= randomMsg();
                rspPushedLast = 1'b1;
            end else begin
                coreRspValid <= 1'b0;
                rspPushedLast = 1'b0;
            end
        end
        @(posedge QClk);
        reqInValid   <= 1'b0;
        rspInValid   <= 1'b0;
        coreReqValid <= 1'b0;
        coreRspValid <= 1'b0;
        drainWait = 0;
        while ((reqSb.size() > 0 || rspSb.size() > 0) && drainWait < 50) begin
            @(posedge QClk);
            drainWait++;
        end
        repeat (4) @(posedge QClk);  // Last forwards leave the pipeline
        if (reqSb.size() == 0 && rspSb.size() == 0 && u_dut.u_props.failCount == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Scoreboards not drained or an assertion failed");
            $display("sim failed");
            $fatal(1, "Run ended with errors");
        end
    end

    initial begin : watchdog
        #(WatchdogTime);
        $display("Timeout: the run did not finish within %0d ns", WatchdogTime);
        $display("sim failed");
        $fatal(1, "Watchdog expired");
    end

endmodule : ringCtrlTb

`default_nettype wire

// File: tb/ringCtrl_properties.sv
// Bound checks for the ring controller
// Reset state, stall discipline toward the core and ventilation limit
`default_nettype none

module ringCtrlProperties #(
    parameter int VentLimit = 3
) (
    input wire logic QClk,
    input wire logic reset,
    input wire logic reqOutValid,
    input wire logic rspOutValid,
    input wire logic coreInReqValid,
    input wire logic coreInRspValid,
    input wire logic coreReqValid,
    input wire logic coreReqStall,
    input wire logic coreRspValid,
    input wire logic coreRspStall,
    input wire logic reqPop,   // Request egress took its queue head
    input wire logic rspPop
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;  // Failed assertions so far
    int reqRun;         // Local insertions in a row
    int rspRun;

    always_ff @(posedge QClk) begin
        if (reset) begin
            reqRun <= 0;
            rspRun <= 0;
        end else begin
            reqRun <= reqPop ? reqRun + 1 : 0;  // Bubble or forward ends the run
            rspRun <= rspPop ? rspRun + 1 : 0;
        end
    end

    //========================================
    // Assertions
    //========================================
    resetClears: assert property (@(posedge QClk) reset |=> !reqOutValid && !rspOutValid
            && !coreInReqValid && !coreInRspValid && !coreReqStall && !coreRspStall)
        else begin
            failCount++;
            $error("Outputs or stall levels not low after reset");
        end

    reqPushLegal: assert property (@(posedge QClk) disable iff (reset)
            coreReqValid |-> !coreReqStall)
        else begin
            failCount++;
            $error("Core request pushed while the request queue is full");
        end

    rspPushLegal: assert property (@(posedge QClk) disable iff (reset)
            coreRspValid |-> !coreRspStall)
        else begin
            failCount++;
            $error("Core response pushed while the response queue is full");
        end

    reqVentLimit: assert property (@(posedge QClk) disable iff (reset) reqRun <= VentLimit)
        else begin
            failCount++;
            $error("Request egress inserted too many messages without a bubble");
        end

    rspVentLimit: assert property (@(posedge QClk) disable iff (reset) rspRun <= VentLimit)
        else begin
            failCount++;
            $error("Response egress inserted too many messages without a bubble");
        end

endmodule : ringCtrlProperties

bind ringCtrl ringCtrlProperties #(.VentLimit(VentLimit)) u_props (
    .QClk           (QClk),
    .reset          (reset),
    .reqOutValid    (reqOutValid),
    .rspOutValid    (rspOutValid),
    .coreInReqValid (coreInReqValid),
    .coreInRspValid (coreInRspValid),
    .coreReqValid   (coreReqValid),
    .coreReqStall   (coreReqStall),
    .coreRspValid   (coreRspValid),
    .coreRspStall   (coreRspStall),
    .reqPop         (reqPop),
    .rspPop         (rspPop)
);

`default_nettype wire

// File: design/ringCtrl.sv
// Ring controller top level
// Request and response ingress stages
// Local queues and egress stages for both ring channels
`default_nettype none

module ringCtrl #(
    parameter int QueueDepth = 4,
    parameter int VentLimit  = 3
) (
    input  wire logic                                QClk,
    input  wire logic                                reset,
    input  wire logic [ringPkg::CoreIdWidth-1:0]     coreId,
    // Ring inputs
    input  wire logic                                reqInValid,
    input  wire ringPkg::ringMsg_t                   reqInMsg,
    input  wire logic                                rspInValid,
    input  wire ringPkg::ringMsg_t                   rspInMsg,
    // Ring outputs
    output logic                                     reqOutValid,
    output ringPkg::ringMsg_t                        reqOutMsg,
    output logic                                     rspOutValid,
    output ringPkg::ringMsg_t                        rspOutMsg,
    // Core requests toward the ring
    input  wire logic                                coreReqValid,
    input  wire ringPkg::opcode_t                    coreReqOpcode,
    input  wire logic [ringPkg::AddrWidth-1:0]       coreReqAddress,
    input  wire logic [ringPkg::DataWidth-1:0]       coreReqData,
    input  wire logic [ringPkg::ThreadIdWidth-1:0]   coreReqThread,
    output logic                                     coreReqStall,
    // Core responses toward the ring
    input  wire logic                                coreRspValid,
    input  wire ringPkg::ringMsg_t                   coreRspMsg,
    output logic                                     coreRspStall,
    // Ring requests delivered to the core
    output logic                                     coreInReqValid,
    output ringPkg::opcode_t                         coreInReqOpcode,
    output logic [ringPkg::AddrWidth-1:0]            coreInReqAddress,
    output logic [ringPkg::DataWidth-1:0]            coreInReqData,
    // Ring responses returned to the core
    output logic                                     coreInRspValid,
    output ringPkg::opcode_t                         coreInRspOpcode,
    output logic [ringPkg::DataWidth-1:0]            coreInRspData,
    output logic [ringPkg::ThreadIdWidth-1:0]        coreInRspThread
);

    logic              reqFwdValid;  // Request ring pass-through
    ringPkg::ringMsg_t reqFwdMsg;
    logic              rspFwdValid;  // Response ring pass-through
    ringPkg::ringMsg_t rspFwdMsg;
    ringPkg::ringMsg_t coreReqMsg;   // Core request as a ring message
    logic              reqHeadValid;
    ringPkg::ringMsg_t reqHeadMsg;
    logic              reqPop;
    logic              rspHeadValid;
    ringPkg::ringMsg_t rspHeadMsg;
    logic              rspPop;

    // Requestor is this core plus the issuing thread
    always_comb begin
        coreReqMsg.requestor = {coreId, coreReqThread};
        coreReqMsg.opcode    = coreReqOpcode;
        coreReqMsg.address   = coreReqAddress;
        coreReqMsg.data      = coreReqData;
    end

    //========================================
    // Request channel
    //========================================
    reqIngress u_reqIngress (
        .QClk             (QClk),
        .reset            (reset),
        .coreId           (coreId),
        .reqInValid       (reqInValid),
        .reqInMsg         (reqInMsg),
        .fwdValid         (reqFwdValid),
        .fwdMsg           (reqFwdMsg),
        .coreInReqValid   (coreInReqValid),
        .coreInReqOpcode  (coreInReqOpcode),
        .coreInReqAddress (coreInReqAddress),
        .coreInReqData    (coreInReqData)
    );

    localQueue #(.QueueDepth(QueueDepth)) reqQueue (
        .QClk      (QClk),
        .reset     (reset),
        .push      (coreReqValid),
        .pushMsg   (coreReqMsg),
        .pop       (reqPop),
        .headValid (reqHeadValid),
        .headMsg   (reqHeadMsg),
        .full      (coreReqStall)  // Full queue holds the core
    );

    ringEgress #(.VentLimit(VentLimit)) reqEgress (
        .QClk      (QClk),
        .reset     (reset),
        .fwdValid  (reqFwdValid),
        .fwdMsg    (reqFwdMsg),
        .headValid (reqHeadValid),
        .headMsg   (reqHeadMsg),
        .pop       (reqPop),
        .outValid  (reqOutValid),
        .outMsg    (reqOutMsg)
    );

    //========================================
    // Response channel
    //========================================
    rspIngress u_rspIngress (
        .QClk            (QClk),
        .reset           (reset),
        .coreId          (coreId),
        .rspInValid      (rspInValid),
        .rspInMsg        (rspInMsg),
        .fwdValid        (rspFwdValid),
        .fwdMsg          (rspFwdMsg),
        .coreInRspValid  (coreInRspValid),
        .coreInRspOpcode (coreInRspOpcode),
        .coreInRspData   (coreInRspData),
        .coreInRspThread (coreInRspThread)
    );

    localQueue #(.QueueDepth(QueueDepth)) rspQueue (
        .QClk      (QClk),
        .reset     (reset),
        .push      (coreRspValid),
        .pushMsg   (coreRspMsg),   // Core supplies its own requestor
        .pop       (rspPop),
        .headValid (rspHeadValid),
        .headMsg   (rspHeadMsg),
        .full      (coreRspStall)
    );

    ringEgress #(.VentLimit(VentLimit)) rspEgress (
        .QClk      (QClk),
        .reset     (reset),
        .fwdValid  (rspFwdValid),
        .fwdMsg    (rspFwdMsg),
        .headValid (rspHeadValid),
        .headMsg   (rspHeadMsg),
        .pop       (rspPop),
        .outValid  (rspOutValid),
        .outMsg    (rspOutMsg)
    );

endmodule : ringCtrl

`default_nettype wire

// File: design/ringEgress.sv
// Ring egress stage
// Slot choice between forward, ventilation bubble and local insertion
// Ventilation counter and the ring output register
`default_nettype none

module ringEgress #(
    parameter int VentLimit = 3
) (
    input  wire logic              QClk,
    input  wire logic              reset,
    input  wire logic              fwdValid,   // Ring traffic to pass on
    input  wire ringPkg::ringMsg_t fwdMsg,
    input  wire logic              headValid,  // Local queue not empty
    input  wire ringPkg::ringMsg_t headMsg,
    output logic                   pop,        // Head taken this cycle
    output logic                   outValid,
    output ringPkg::ringMsg_t      outMsg
);

    localparam int CountWidth = $clog2(VentLimit + 1);

    ringPkg::egressSel_t   sel;
    logic [CountWidth-1:0] ventCount;  // Consecutive insertions
    logic                  ventDue;

    assign ventDue = (ventCount == CountWidth'(VentLimit));

    //========================================
    // Slot choice
    //========================================
    // Ring traffic first, then ventilation, then local queue
    always_comb begin
        if (fwdValid) begin
            sel = ringPkg::RingInput;
        end else if (ventDue) begin
            sel = ringPkg::BubbleOut;   // Forced empty slot
        end else if (headValid) begin
            sel = ringPkg::LocalInsert;
        end else begin
            sel = ringPkg::BubbleOut;   // Nothing to send
        end
    end

    assign pop = (sel == ringPkg::LocalInsert);

    //========================================
    // Ventilation counter
    //========================================
    // Never passes VentLimit, insertion is blocked once it gets there
    always_ff @(posedge QClk) begin
        if (reset) begin
            ventCount <= '0;
        end else begin
            case (sel)
                ringPkg::LocalInsert: ventCount <= ventCount + 1'b1;
                ringPkg::BubbleOut:   ventCount <= '0;
                default:              ventCount <= ventCount;  // Forward holds
            endcase
        end
    end

    //========================================
    // Ring output register
    //========================================
    always_ff @(posedge QClk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= (sel != ringPkg::BubbleOut);
        end
    end

    always_ff @(posedge QClk) begin
        case (sel)
            ringPkg::RingInput:   outMsg <= fwdMsg;
            ringPkg::LocalInsert: outMsg <= headMsg;
            default:              outMsg <= '0;  // Bubble goes out zeroed
        endcase
    end

endmodule : ringEgress

`default_nettype wire

// File: design/rspIngress.sv
// Response ring ingress stage
// Input register and requestor match
// Returns own responses to the core with their thread, forwards the rest
`default_nettype none

module rspIngress (
    input  wire logic                                QClk,
    input  wire logic                                reset,
    input  wire logic [ringPkg::CoreIdWidth-1:0]     coreId,
    input  wire logic                                rspInValid,
    input  wire ringPkg::ringMsg_t                   rspInMsg,
    output logic                                     fwdValid,
    output ringPkg::ringMsg_t                        fwdMsg,
    output logic                                     coreInRspValid,
    output ringPkg::opcode_t                         coreInRspOpcode,
    output logic [ringPkg::DataWidth-1:0]            coreInRspData,
    output logic [ringPkg::ThreadIdWidth-1:0]       coreInRspThread
);

    logic              inValid;  // Registered ring input
    ringPkg::ringMsg_t inMsg;
    logic              match;    // Response belongs to this core

    // Ring input register
    always_ff @(posedge QClk) begin
        if (reset) begin
            inValid <= 1'b0;
        end else begin
            inValid <= rspInValid;
        end
    end

    always_ff @(posedge QClk) begin
        inMsg <= rspInMsg;
    end

    assign match = (inMsg.requestor[ringPkg::RequestorWidth-1 -: ringPkg::CoreIdWidth] == coreId);

    assign fwdValid = inValid && !match;  // Someone else's response
    assign fwdMsg   = inMsg;

    //========================================
    // Delivery register toward the core
    //========================================
    always_ff @(posedge QClk) begin
        if (reset) begin
            coreInRspValid <= 1'b0;
        end else begin
            coreInRspValid <= inValid && match;
        end
    end

    always_ff @(posedge QClk) begin
        coreInRspOpcode <= inMsg.opcode;
        coreInRspData   <= inMsg.data;
        coreInRspThread <= inMsg.requestor[ringPkg::ThreadIdWidth-1:0];  // Low bits
    end

endmodule : rspIngress

`default_nettype wire

// File: design/reqIngress.sv
// Request ring ingress stage
// Input register, target match and broadcast removal
// Forward candidate after one cycle, core delivery after two
`default_nettype none

module reqIngress (
    input  wire logic                                QClk,
    input  wire logic                                reset,
    input  wire logic [ringPkg::CoreIdWidth-1:0]     coreId,
    input  wire logic                                reqInValid,
    input  wire ringPkg::ringMsg_t                   reqInMsg,
    output logic                                     fwdValid,
    output ringPkg::ringMsg_t                        fwdMsg,
    output logic                                     coreInReqValid,
    output ringPkg::opcode_t                         coreInReqOpcode,
    output logic [ringPkg::AddrWidth-1:0]            coreInReqAddress,
    output logic [ringPkg::DataWidth-1:0]            coreInReqData
);

    logic                            inValid;   // Registered ring input
    ringPkg::ringMsg_t               inMsg;
    logic [ringPkg::CoreIdWidth-1:0] targetCore;
    logic [ringPkg::CoreIdWidth-1:0] srcCore;
    logic                            forMe;
    logic                            isBcast;
    logic                            ownBcast;  // Came all the way around
    logic                            deliver;

    //========================================
    // Ring input register
    //========================================
    always_ff @(posedge QClk) begin
        if (reset) begin
            inValid <= 1'b0;
        end else begin
            inValid <= reqInValid;
        end
    end

    always_ff @(posedge QClk) begin
        inMsg <= reqInMsg;  // Payload, no reset
    end

    //========================================
    // Request rule
    //========================================
    assign targetCore = inMsg.address[ringPkg::AddrWidth-1 -: ringPkg::CoreIdWidth];
    assign srcCore    = inMsg.requestor[ringPkg::RequestorWidth-1 -: ringPkg::CoreIdWidth];
    assign forMe      = (targetCore == coreId);
    assign isBcast    = (inMsg.opcode == ringPkg::WrBcast);
    assign ownBcast   = isBcast && (srcCore == coreId);

    // Broadcast from another core goes both ways
    assign deliver  = inValid && ((forMe && !isBcast) || (isBcast && !ownBcast));
    assign fwdValid = inValid && !ownBcast && (isBcast || !forMe);
    assign fwdMsg   = inMsg;

    //========================================
    // Delivery register toward the core
    //========================================
    always_ff @(posedge QClk) begin
        if (reset) begin
            coreInReqValid <= 1'b0;
        end else begin
            coreInReqValid <= deliver;
        end
    end

    always_ff @(posedge QClk) begin
        coreInReqOpcode  <= inMsg.opcode;
        coreInReqAddress <= inMsg.address;
        coreInReqData    <= inMsg.data;
    end

endmodule : reqIngress

`default_nettype wire

// File: design/localQueue.sv
// Local message queue
// Circular FIFO of ring messages waiting for a free ring slot
`default_nettype none

module localQueue #(
    parameter int QueueDepth = 4
) (
    input  wire logic             QClk,
    input  wire logic             reset,
    input  wire logic             push,      // One message from the core
    input  wire ringPkg::ringMsg_t pushMsg,
    input  wire logic             pop,       // Egress took the head
    output logic                  headValid,
    output ringPkg::ringMsg_t     headMsg,
    output logic                  full       // Stall level toward the core
);

    localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountWidth = $clog2(QueueDepth + 1);

    ringPkg::ringMsg_t     mem [QueueDepth];  // Payload storage
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;             // Occupancy
    logic                  wrEn;
    logic                  rdEn;

    // Push into a full queue is dropped
    assign wrEn = push && !full;
    assign rdEn = pop && headValid;

    assign headValid = (count != '0);
    assign full      = (count == CountWidth'(QueueDepth));
    assign headMsg   = mem[rdPtr];  // Head shown without delay

    // Pointers and occupancy
    always_ff @(posedge QClk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge QClk) begin
        if (wrEn) begin
            mem[wrPtr] <= pushMsg;
        end
    end

endmodule : localQueue

`default_nettype wire

// File: design/ringPkg.sv
// Shared ring definitions
// Field widths, message kinds and the egress choice
// Ring message layout used on both ring channels
`default_nettype none

package ringPkg;

    //========================================
    // Widths
    //========================================
    parameter int CoreIdWidth    = 8;  // Core number
    parameter int ThreadIdWidth  = 2;  // Thread inside a core
    parameter int RequestorWidth = CoreIdWidth + ThreadIdWidth;  // Core above thread
    parameter int AddrWidth      = 32;
    parameter int DataWidth      = 32;

    //========================================
    // Message kinds
    //========================================
    typedef enum logic [1:0] {
        Rd      = 2'b00,  // Read request
        Wr      = 2'b01,  // Write request
        WrBcast = 2'b10,  // Write seen by every core
        RdRsp   = 2'b11   // Read data coming back
    } opcode_t;

    // Egress choice per cycle
    typedef enum logic [1:0] {
        BubbleOut   = 2'b00,  // Empty slot
        RingInput   = 2'b01,  // Traffic already on the ring
        LocalInsert = 2'b10   // Head of the local queue
    } egressSel_t;

    //========================================
    // Ring message, 76 bits
    //========================================
    // Top CoreIdWidth bits of address name the target core of a request
    typedef struct packed {
        logic [RequestorWidth-1:0] requestor;  // {core, thread}
        opcode_t                   opcode;
        logic [AddrWidth-1:0]      address;
        logic [DataWidth-1:0]      data;
    } ringMsg_t;

endpackage : ringPkg

`default_nettype wire
